// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_video_udp
FILELIST  ?= video_udp.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== net_pkg.sv ====
package net_pkg;

   // Packet layout, header then one byte per pixel
   localparam int C_HDR_BYTES = 5;
   localparam int C_PKT_BYTES = C_HDR_BYTES + int'(vid_pkg::C_COLS);

   localparam int C_FIFO_DEPTH = 64;

   // Free-space count, 0 up to C_FIFO_DEPTH
   typedef logic [$clog2(C_FIFO_DEPTH):0] fifo_cnt_t;

   localparam logic [7:0] C_SYNC0 = 8'hCA;
   localparam logic [7:0] C_SYNC1 = 8'hFE;

   typedef struct packed {
      logic       last;
      logic [7:0] data;
   } tx_byte_t;

   // APB register map
   localparam logic [7:0] C_REG_CTRL = 8'h00;
   localparam logic [7:0] C_REG_SENT = 8'h04;
   localparam logic [7:0] C_REG_DROP = 8'h08;

endpackage

// ==== rgb2udp.sv ====
module rgb2udp (
   input  logic               clk,
   input  logic               rst,
   input  logic               enable,
   input  vid_pkg::vid_beat_t vid_beat,
   input  net_pkg::fifo_cnt_t free_cnt,
   output logic               wr_en,
   output net_pkg::tx_byte_t  wr_byte,
   output logic               pkt_done,
   output logic               row_dropped
);

   typedef enum logic [1:0] {
      st_idle,
      st_header,
      st_pixels
   } state_t;

   state_t      state;
   logic [2:0]  hdr_idx;
   logic [3:0]  frame_num;
   logic        frame_en;
   logic [15:0] row_q;

   logic        row_sel;
   logic        pkt_fits;
   logic        last_col;
   logic [7:0]  hdr_byte;
   logic [7:0]  rgb332;

   // ---------------------------------------------------------------------------
   // Row selection and packing
   // ---------------------------------------------------------------------------

   // Rows rotate with the frame number
   assign row_sel = vid_beat.sol && frame_en
                 && (vid_beat.row < vid_pkg::C_ROWS)
                 && ((vid_beat.row % vid_pkg::C_ROW_PHASES)
                     == (frame_num % vid_pkg::C_ROW_PHASES));

   // Whole packet must fit or the row goes
   assign pkt_fits = free_cnt >= net_pkg::fifo_cnt_t'(net_pkg::C_PKT_BYTES);

   assign last_col = vid_beat.col == (vid_pkg::C_COLS - 16'd1);

   assign rgb332 = {vid_beat.pix.r[7:5], vid_beat.pix.g[7:5], vid_beat.pix.b[7:6]};

   always_comb begin
      case (hdr_idx)
         3'd0:    hdr_byte = net_pkg::C_SYNC0;
         3'd1:    hdr_byte = net_pkg::C_SYNC1;
         3'd2:    hdr_byte = {4'h0, frame_num};
         3'd3:    hdr_byte = row_q[15:8];
         default: hdr_byte = row_q[7:0];
      endcase
   end

   // ---------------------------------------------------------------------------
   // Packet FSM
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= st_idle;
         hdr_idx     <= '0;
         frame_num   <= '0;
         frame_en    <= 1'b0;
         wr_en       <= 1'b0;
         pkt_done    <= 1'b0;
         row_dropped <= 1'b0;
      end else begin
         wr_en       <= 1'b0;
         pkt_done    <= 1'b0;
         row_dropped <= 1'b0;

         // Enable only changes at a frame boundary
         if (vid_beat.sof) begin
            frame_en <= enable;
         end
         if (vid_beat.eof) begin
            if (frame_num == 4'(vid_pkg::C_FRAME_MOD - 1)) begin
               frame_num <= '0;
            end else begin
               frame_num <= frame_num + 4'd1;
            end
         end

         case (state)
            st_idle: begin
               if (row_sel) begin
                  if (pkt_fits) begin
                     // First marker goes out with this transition
                     wr_en   <= 1'b1;
                     hdr_idx <= 3'd1;
                     state   <= st_header;
                  end else begin
                     row_dropped <= 1'b1;
                  end
               end
            end
            st_header: begin
               wr_en <= 1'b1;
               if (hdr_idx == 3'(net_pkg::C_HDR_BYTES - 1)) begin
                  hdr_idx <= '0;
                  state   <= st_pixels;
               end else begin
                  hdr_idx <= hdr_idx + 3'd1;
               end
            end
            st_pixels: begin
               if (vid_beat.pix_valid) begin
                  wr_en <= 1'b1;
                  if (last_col) begin
                     pkt_done <= 1'b1;
                     state    <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Byte payload, qualified by wr_en
   always_ff @(posedge clk) begin
      if (state == st_idle && vid_beat.sol) begin
         row_q <= vid_beat.row;
      end
      if (state == st_pixels) begin
         wr_byte <= '{last: last_col, data: rgb332};
      end else begin
         wr_byte <= '{last: 1'b0, data: hdr_byte};
      end
   end

endmodule

// ==== tb_video_udp.sv ====
module tb_video_udp;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int C_COLS            = int'(vid_pkg::C_COLS);
   localparam int C_ROWS            = int'(vid_pkg::C_ROWS);
   localparam int C_LINE_CYCLES     = 1 + 8 + C_COLS + 3;
   localparam int C_FRAME_CYCLES    = 3 + C_ROWS * C_LINE_CYCLES + 4;
   localparam int C_NUM_FRAMES      = 28;
   localparam int C_WATCHDOG_CYCLES = C_NUM_FRAMES * C_FRAME_CYCLES * 3 + 4000;
   localparam int C_DRAIN_LIMIT     = 2000;
   localparam int C_READY_HIGH      = 0;
   localparam int C_READY_RANDOM    = 1;
   localparam int C_READY_LOW       = 2;

   logic          clk = 1'b0;
   logic          rst;
   logic          in_frame;
   logic          in_line;
   logic          data_in_en;
   vid_pkg::pix_t data_in;
   logic          tx_ready;
   logic [7:0]    tx_data;
   logic          tx_last;
   logic          tx_valid;
   logic          psel;
   logic          penable;
   logic          pwrite;
   logic [7:0]    paddr;
   logic [31:0]   pwdata;
   logic [31:0]   prdata;
   logic          pready;

   net_pkg::tx_byte_t exp_q[$];
   vid_pkg::pix_t     pix_store [C_ROWS][C_COLS];
   int    frame_cnt = 0;
   int    exp_sent = 0;
   int    exp_drop = 0;
   int    ready_mode = C_READY_HIGH;
   int    valid_cycles = 0;
   int    test_checks = 0;
   int    test_errors = 0;
   int    total_errors = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   bit    cfg_enable = 1'b0;
   bit    frame_enable = 1'b0;
   string test_name = "reset";

   video_udp_top i_dut (.*);

   always #50 clk = ~clk;

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------
   function automatic net_pkg::tx_byte_t expected_byte(int frame, int row, int idx,
                                                       vid_pkg::pix_t px);
      net_pkg::tx_byte_t b;
      b.last = (idx == net_pkg::C_PKT_BYTES - 1);
      case (idx)
         0:       b.data = 8'hCA;
         1:       b.data = 8'hFE;
         2:       b.data = 8'(frame % vid_pkg::C_FRAME_MOD);
         3:       b.data = 8'(row >> 8);
         4:       b.data = 8'(row);
         default: b.data = {px.r[7:5], px.g[7:5], px.b[7:6]};
      endcase
      return b;
   endfunction

   task automatic queue_packet(int row);
      vid_pkg::pix_t px;
      for (int i = 0; i < net_pkg::C_PKT_BYTES; i++) begin
         px = (i < net_pkg::C_HDR_BYTES) ? '0 : pix_store[row][i - net_pkg::C_HDR_BYTES];
         exp_q.push_back(expected_byte(frame_cnt, row, i, px));
      end
   endtask

   // FIFO occupancy estimate; the output register holds one byte when data waits
   task automatic plan_row(int row);
      int pending;
      int free_slots;
      pending    = exp_q.size();
      free_slots = net_pkg::C_FIFO_DEPTH - pending + ((pending > 0) ? 1 : 0);
      if (frame_enable && (row % vid_pkg::C_ROW_PHASES) == (frame_cnt % vid_pkg::C_ROW_PHASES)) begin
         if (free_slots >= net_pkg::C_PKT_BYTES) begin
            queue_packet(row);
            exp_sent++;
         end else begin
            exp_drop++;
         end
      end
   endtask

   // ------------------------------------------------------------------------
   // Checks and reporting
   // ------------------------------------------------------------------------
   task automatic report_error(string msg);
      test_errors++;
      $display("ERROR in %s: %s", test_name, msg);
   endtask

   task automatic check_byte(string name, net_pkg::tx_byte_t exp, net_pkg::tx_byte_t act);
      test_checks++;
      if (act !== exp) begin
         test_errors++;
         $display("FAIL %s: expected last=%0b data=%02h, actual last=%0b data=%02h",
                  name, exp.last, exp.data, act.last, act.data);
      end
   endtask

   task automatic check_reg(string name, logic [31:0] exp, logic [31:0] act);
      test_checks++;
      if (act !== exp) begin
         test_errors++;
         $display("FAIL %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("%-14s %0d checks, %0d errors", test_name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   task automatic drive_line(int row);
      for (int c = 0; c < C_COLS; c++) begin
         pix_store[row][c] = 24'($urandom);
      end
      plan_row(row);
      @(posedge clk);
      in_line <= 1'b1;
      repeat (8) @(posedge clk);
      for (int c = 0; c < C_COLS; c++) begin
         data_in_en <= 1'b1;
         data_in    <= pix_store[row][c];
         @(posedge clk);
      end
      data_in_en <= 1'b0;
      in_line    <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   task automatic drive_frame();
      frame_enable = cfg_enable;
      @(posedge clk);
      in_frame <= 1'b1;
      repeat (2) @(posedge clk);
      for (int r = 0; r < C_ROWS; r++) begin
         drive_line(r);
      end
      in_frame <= 1'b0;
      repeat (4) @(posedge clk);
      frame_cnt++;
   endtask

   task automatic apb_write(logic [7:0] addr, logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      // Access cycle value
      data = prdata;
      if (pready !== 1'b1) begin
         report_error("pready was low in the APB access cycle");
      end
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_counters(string tag);
      logic [31:0] rd;
      apb_read(net_pkg::C_REG_SENT, rd);
      check_reg({tag, " SENT"}, 32'(exp_sent), rd);
      apb_read(net_pkg::C_REG_DROP, rd);
      check_reg({tag, " DROP"}, 32'(exp_drop), rd);
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while ((exp_q.size() != 0 || tx_valid) && cycles < C_DRAIN_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_q.size() != 0) begin
         report_error($sformatf("%0d expected bytes never left the DUT", exp_q.size()));
      end
   endtask

   // Sink ready pattern
   initial begin
      tx_ready <= 1'b1;
      forever begin
         @(posedge clk);
         case (ready_mode)
            C_READY_RANDOM: tx_ready <= ($urandom_range(0, 1) == 1);
            C_READY_LOW:    tx_ready <= 1'b0;
            default:        tx_ready <= 1'b1;
         endcase
      end
   end

   // Output byte comparison on each handshake
   always @(posedge clk) begin
      net_pkg::tx_byte_t act;
      act = '{last: tx_last, data: tx_data};
      if (tx_valid === 1'b1) begin
         valid_cycles++;
      end
      if (!rst && tx_valid && tx_ready) begin
         if (exp_q.size() == 0) begin
            report_error($sformatf("unexpected byte %02h came out of the DUT", tx_data));
         end else begin
            check_byte(test_name, exp_q.pop_front(), act);
         end
      end
   end

   initial begin
      repeat (C_WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", C_WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial begin
      logic [31:0] rd;
      int          valid_before;
      rst        <= 1'b1;
      in_frame   <= 1'b0;
      in_line    <= 1'b0;
      data_in_en <= 1'b0;
      data_in    <= '0;
      psel       <= 1'b0;
      penable    <= 1'b0;
      pwrite     <= 1'b0;
      paddr      <= '0;
      pwdata     <= '0;
      // Seed the generator once
      rd = $urandom(32'h3182_c704);

      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
         if (i > 0 && tx_valid !== 1'b0) begin
            report_error("tx_valid was high during reset");
         end
      end
      rst <= 1'b0;
      repeat (4) @(posedge clk);
      if (tx_valid !== 1'b0) begin
         report_error("tx_valid was high right after reset");
      end
      apb_read(net_pkg::C_REG_CTRL, rd);
      check_reg("reset CTRL", 32'd0, rd);
      check_counters("reset");
      finish_test();

      test_name = "packet_format";
      apb_write(net_pkg::C_REG_CTRL, 32'd1);
      cfg_enable = 1'b1;
      repeat (4) drive_frame();
      wait_drain();
      check_counters("packet_format");
      finish_test();

      // Frame byte wraps past 15 in here
      test_name = "row_rotation";
      repeat (18) drive_frame();
      wait_drain();
      check_counters("row_rotation");
      finish_test();

      test_name  = "back_pressure";
      ready_mode = C_READY_RANDOM;
      repeat (4) drive_frame();
      wait_drain();
      ready_mode = C_READY_HIGH;
      check_counters("back_pressure");
      finish_test();

      test_name  = "overflow";
      ready_mode = C_READY_LOW;
      repeat (2) @(posedge clk);
      drive_frame();
      check_counters("overflow");
      ready_mode = C_READY_HIGH;
      wait_drain();
      finish_test();

      test_name = "enable_regs";
      apb_write(net_pkg::C_REG_CTRL, 32'd0);
      cfg_enable = 1'b0;
      apb_read(net_pkg::C_REG_CTRL, rd);
      check_reg("enable_regs CTRL 0", 32'd0, rd);
      valid_before = valid_cycles;
      drive_frame();
      if (valid_cycles != valid_before) begin
         report_error("tx_valid went high in a disabled frame");
      end
      apb_write(net_pkg::C_REG_CTRL, 32'd1);
      apb_read(net_pkg::C_REG_CTRL, rd);
      check_reg("enable_regs CTRL 1", 32'd1, rd);
      apb_write(net_pkg::C_REG_SENT, 32'h1234_5678);
      apb_write(net_pkg::C_REG_DROP, 32'hffff_ffff);
      exp_sent = 0;
      exp_drop = 0;
      check_counters("enable_regs cleared");
      finish_test();

      $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
      if (total_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== tx_fifo.sv ====
module tx_fifo (
   input  logic               clk,
   input  logic               rst,
   input  logic               wr_en,
   input  net_pkg::tx_byte_t  wr_byte,
   input  logic               tx_ready,
   output net_pkg::fifo_cnt_t free_cnt,
   output logic [7:0]         tx_data,
   output logic               tx_last,
   output logic               tx_valid
);

   net_pkg::tx_byte_t mem [net_pkg::C_FIFO_DEPTH];
   net_pkg::tx_byte_t out_q;

   logic [$clog2(net_pkg::C_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(net_pkg::C_FIFO_DEPTH)-1:0] rd_ptr;
   net_pkg::fifo_cnt_t                       count;

   logic load_out;
   logic bypass;
   logic mem_wr;
   logic mem_rd;

   // Output slot is free next cycle if empty or being taken now
   assign load_out = !tx_valid || tx_ready;
   // Straight into the output register when the array is empty
   assign bypass   = load_out && (count == '0) && wr_en;
   assign mem_wr   = wr_en && !bypass;
   assign mem_rd   = load_out && (count != '0);

   assign free_cnt = net_pkg::fifo_cnt_t'(net_pkg::C_FIFO_DEPTH) - count;
   assign tx_data  = out_q.data;
   assign tx_last  = out_q.last;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         tx_valid <= 1'b0;
      end else begin
         if (mem_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (mem_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + net_pkg::fifo_cnt_t'(mem_wr) - net_pkg::fifo_cnt_t'(mem_rd);
         if (load_out) begin
            tx_valid <= mem_rd || bypass;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wr) begin
         mem[wr_ptr] <= wr_byte;
      end
      if (mem_rd) begin
         out_q <= mem[rd_ptr];
      end else if (bypass) begin
         out_q <= wr_byte;
      end
   end

endmodule

// ==== vid_pkg.sv ====
package vid_pkg;

   // ---------------------------------------------------------------------------
   // Active frame geometry
   // ---------------------------------------------------------------------------
   localparam logic [15:0] C_COLS = 16'd32;
   localparam logic [15:0] C_ROWS = 16'd8;

   // Frame counter wraps here
   localparam int C_FRAME_MOD = 16;

   // One row in this many goes out per frame
   localparam int C_ROW_PHASES = 4;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } pix_t;

   // One cycle of the decoded video stream
   typedef struct packed {
      logic        sof;
      logic        sol;
      logic        eol;
      logic        eof;
      logic        pix_valid;
      logic [15:0] col;
      logic [15:0] row;
      pix_t        pix;
   } vid_beat_t;

endpackage

// ==== video_rx.sv ====
module video_rx (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_frame,
   input  logic              in_line,
   input  logic              data_in_en,
   input  vid_pkg::pix_t     data_in,
   output vid_pkg::vid_beat_t vid_beat
);

   logic        frame_q;
   logic        line_q;
   logic [15:0] col_cnt;
   logic [15:0] row_cnt;

   // ---------------------------------------------------------------------------
   // Strobe history and position counters
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         frame_q <= 1'b0;
         line_q  <= 1'b0;
         col_cnt <= '0;
         row_cnt <= '0;
      end else begin
         frame_q <= in_frame;
         line_q  <= in_line;
         if (in_line && !line_q) begin
            col_cnt <= '0;
         end else if (data_in_en) begin
            col_cnt <= col_cnt + 16'd1;
         end
         // Row advances once the line has ended
         if (in_frame && !frame_q) begin
            row_cnt <= '0;
         end else if (line_q && !in_line) begin
            row_cnt <= row_cnt + 16'd1;
         end
      end
   end

   // Beat output, one cycle behind the inputs
   always_ff @(posedge clk) begin
      vid_beat.col <= col_cnt;
      vid_beat.row <= row_cnt;
      vid_beat.pix <= data_in;
      if (rst) begin
         vid_beat.sof       <= 1'b0;
         vid_beat.sol       <= 1'b0;
         vid_beat.eol       <= 1'b0;
         vid_beat.eof       <= 1'b0;
         vid_beat.pix_valid <= 1'b0;
      end else begin
         vid_beat.sof       <= in_frame && !frame_q;
         vid_beat.sol       <= in_line && !line_q;
         vid_beat.eol       <= line_q && !in_line;
         vid_beat.eof       <= frame_q && !in_frame;
         vid_beat.pix_valid <= data_in_en;
      end
   end

endmodule

// ==== video_udp.f ====
vid_pkg.sv
net_pkg.sv
video_rx.sv
rgb2udp.sv
tx_fifo.sv
video_udp_regs.sv
video_udp_top.sv
video_udp_assertions.sv
tb_video_udp.sv

// ==== video_udp_assertions.sv ====
module video_udp_assertions (
   input logic               clk,
   input logic               rst,
   input logic               tx_valid,
   input logic               tx_ready,
   input logic [7:0]         tx_data,
   input logic               tx_last,
   input logic               wr_en,
   input net_pkg::fifo_cnt_t free_cnt,
   input logic               pkt_done,
   input logic               row_dropped
);
   timeunit 1ns;
   timeprecision 1ps;

   // Output byte held while the sink stalls
   a_stall_stable: assert property (@(posedge clk) disable iff (rst)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last))
      else $error("tx_data or tx_last changed while tx_ready was low");

   a_no_write_full: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> free_cnt != '0)
      else $error("FIFO written with no free entry");

   // A row is either sent or dropped
   a_done_or_drop: assert property (@(posedge clk) disable iff (rst)
      !(pkt_done && row_dropped))
      else $error("pkt_done and row_dropped high together");

endmodule

bind video_udp_top video_udp_assertions i_assertions (
   .clk         (clk),
   .rst         (rst),
   .tx_valid    (tx_valid),
   .tx_ready    (tx_ready),
   .tx_data     (tx_data),
   .tx_last     (tx_last),
   .wr_en       (wr_en),
   .free_cnt    (free_cnt),
   .pkt_done    (pkt_done),
   .row_dropped (row_dropped)
);

// ==== video_udp_regs.sv ====
module video_udp_regs (
   input  logic        clk,
   input  logic        rst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [7:0]  paddr,
   input  logic [31:0] pwdata,
   input  logic        pkt_done,
   input  logic        row_dropped,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        enable
);

   logic [31:0] sent_cnt;
   logic [31:0] drop_cnt;
   logic        reg_wr;

   // No wait states
   assign pready = 1'b1;
   assign reg_wr = psel && penable && pwrite;

   always_ff @(posedge clk) begin
      if (rst) begin
         enable   <= 1'b0;
         sent_cnt <= '0;
         drop_cnt <= '0;
      end else begin
         if (reg_wr && paddr == net_pkg::C_REG_CTRL) begin
            enable <= pwdata[0];
         end
         // Any write clears a counter
         if (reg_wr && paddr == net_pkg::C_REG_SENT) begin
            sent_cnt <= '0;
         end else if (pkt_done) begin
            sent_cnt <= sent_cnt + 32'd1;
         end
         if (reg_wr && paddr == net_pkg::C_REG_DROP) begin
            drop_cnt <= '0;
         end else if (row_dropped) begin
            drop_cnt <= drop_cnt + 32'd1;
         end
      end
   end

   // Read data valid in the access cycle
   always_comb begin
      case (paddr)
         net_pkg::C_REG_CTRL: prdata = {31'd0, enable};
         net_pkg::C_REG_SENT: prdata = sent_cnt;
         net_pkg::C_REG_DROP: prdata = drop_cnt;
         default:             prdata = '0;
      endcase
   end

endmodule

// ==== video_udp_top.sv ====
module video_udp_top (
   input  logic          clk,
   input  logic          rst,
   input  logic          in_frame,
   input  logic          in_line,
   input  logic          data_in_en,
   input  vid_pkg::pix_t data_in,
   input  logic          tx_ready,
   output logic [7:0]    tx_data,
   output logic          tx_last,
   output logic          tx_valid,
   input  logic          psel,
   input  logic          penable,
   input  logic          pwrite,
   input  logic [7:0]    paddr,
   input  logic [31:0]   pwdata,
   output logic [31:0]   prdata,
   output logic          pready
);

   vid_pkg::vid_beat_t vid_beat;
   net_pkg::tx_byte_t  wr_byte;
   net_pkg::fifo_cnt_t free_cnt;
   logic               wr_en;
   logic               enable;
   logic               pkt_done;
   logic               row_dropped;

   video_rx i_video_rx (
      .clk        (clk),
      .rst        (rst),
      .in_frame   (in_frame),
      .in_line    (in_line),
      .data_in_en (data_in_en),
      .data_in    (data_in),
      .vid_beat   (vid_beat)
   );

   rgb2udp i_rgb2udp (
      .clk         (clk),
      .rst         (rst),
      .enable      (enable),
      .vid_beat    (vid_beat),
      .free_cnt    (free_cnt),
      .wr_en       (wr_en),
      .wr_byte     (wr_byte),
      .pkt_done    (pkt_done),
      .row_dropped (row_dropped)
   );

   tx_fifo i_tx_fifo (
      .clk      (clk),
      .rst      (rst),
      .wr_en    (wr_en),
      .wr_byte  (wr_byte),
      .tx_ready (tx_ready),
      .free_cnt (free_cnt),
      .tx_data  (tx_data),
      .tx_last  (tx_last),
      .tx_valid (tx_valid)
   );

   video_udp_regs i_regs (
      .clk         (clk),
      .rst         (rst),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .pkt_done    (pkt_done),
      .row_dropped (row_dropped),
      .prdata      (prdata),
      .pready      (pready),
      .enable      (enable)
   );

endmodule
